//--- flist.f
common/plic_pkg.sv
plic/plic_regs.sv
plic/plic_gateway.sv
plic/plic_target.sv
verilog/plic_top.sv
tests/plic_props.sv
tests/plic_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the PLIC testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module plic_tb -f flist.f -o plic_sim \
  && ./obj_dir/plic_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "All tests passed!" \
  && { echo "Simulation PASS"; exit 0; } \
  || { echo "Simulation FAIL"; exit 1; }

//--- tests/plic_tb.sv
// PLIC testbench with Wishbone register access, LFSR stimulus and a gateway reference model
`timescale 1ns/1ns

module plic_tb;
  import plic_pkg::*;

  localparam int NSRC = 16;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [NSRC-1:0] intr_src;
  logic        irq;
  logic [3:0]  irq_id;
  logic        msip;

  // Reference model of config, pending and claimed sets
  logic [1:0]      m_prio [NSRC];
  logic [NSRC-1:0] m_ie;
  logic [NSRC-1:0] m_le;
  logic [NSRC-1:0] m_ip;
  logic [NSRC-1:0] m_act;
  logic [1:0]      m_thr;

  logic [15:0] lfsr = 16'd27351;
  logic [31:0] r;
  logic [31:0] rd;
  int          err0;
  int          e;
  int          errors = 0;
  int          checks = 0;

  plic_top dut0 (
    .clk_i (clk), .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w), .wb_sel_i (wb_sel), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
    .intr_src_i (intr_src), .irq_o (irq), .irq_id_o (irq_id), .msip_o (msip)
  );

  // 100 MHz
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois LFSR x^16+x^14+x^13+x^11 stepped once per bit
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Highest priority above threshold with ties to the lowest id
  function automatic logic [3:0] model_pick();
    logic [1:0] bp;
    logic [3:0] id;
    bp = m_thr;
    id = '0;
    for (int s = 1; s < NSRC; s++) begin
      if (m_ip[s] && m_ie[s] && m_prio[s] > bp) begin
        bp = m_prio[s];
        id = 4'(s);
      end
    end
    return id;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_run();
    int total;
    total = errors + dut0.u_props.fail_cnt;
    $display("%0d checks, %0d failures", checks, total);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // Classic cycle driven and sampled on the falling edge
  task automatic wb_access(input logic we, input logic [7:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    rdat = '0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    wb_sel   = 4'hF;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < 20);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!wb_ack) begin
      $display("Wishbone access to %h got no ack within %0d cycles", adr, n);
      errors++;
      end_run();
    end
  endtask

  task automatic reg_read(input logic [7:0] adr, output logic [31:0] val);
    wb_access(1'b0, adr, 32'h0, val);
  endtask

  task automatic reg_write(input logic [7:0] adr, input logic [31:0] val);
    logic [31:0] dummy;
    wb_access(1'b1, adr, val, dummy);
  endtask

  // Source to irq takes two cycles plus one spare
  task automatic settle();
    repeat (3) @(negedge clk);
  endtask

  task automatic check_ip();
    logic [31:0] v;
    reg_read(REG_IP, v);
    check_eq("ip", v, 32'(m_ip));
  endtask

  task automatic check_irq();
    logic [3:0] exp;
    exp = model_pick();
    check_eq("irq_o", 32'(irq), 32'(exp != '0));
    check_eq("irq_id_o", 32'(irq_id), 32'(exp));
  endtask

  // Claim until the model has nothing left
  task automatic claim_all();
    logic [31:0] v;
    logic [3:0]  exp;
    for (int k = 0; k < NSRC; k++) begin
      exp = model_pick();
      reg_read(REG_CC, v);
      check_eq("cc", v, 32'(exp));
      if (exp == '0) break;
      m_ip[exp]  = 1'b0;
      m_act[exp] = 1'b1;
      check_ip();
    end
  endtask

  // Level sources still high pend again
  task automatic complete_all();
    for (int s = 1; s < NSRC; s++) begin
      if (m_act[s]) begin
        reg_write(REG_CC, 32'(s));
        m_act[s] = 1'b0;
        m_ip[s]  = intr_src[s] & ~m_le[s];
      end
    end
    settle();
    check_ip();
  endtask

  task automatic pulse_src(input int s);
    @(negedge clk);
    intr_src[s] = 1'b1;
    @(negedge clk);
    intr_src[s] = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////
  initial begin
    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    intr_src = '0;
    for (int s = 0; s < NSRC; s++) begin
      m_prio[s] = '0;
    end
    m_ie  = '0;
    m_le  = '0;
    m_ip  = '0;
    m_act = '0;
    m_thr = '0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // Readback masked to register widths
    err0 = errors;
    for (int s = 0; s < NSRC; s++) begin
      r = lfsr_take(32);
      reg_write(8'(4 * s), r);
      m_prio[s] = r[1:0];
    end
    for (int s = 0; s < NSRC; s++) begin
      reg_read(8'(4 * s), rd);
      check_eq("prio", rd, 32'(m_prio[s]));
    end
    r = lfsr_take(32);
    reg_write(REG_LE, r);
    m_le = r[15:0];
    reg_read(REG_LE, rd);
    check_eq("le", rd, 32'(m_le));
    r = lfsr_take(32);
    // Enable of reserved source 0 always attempted
    reg_write(REG_IE, r | 32'h1);
    m_ie = {r[15:1], 1'b0};
    reg_read(REG_IE, rd);
    check_eq("ie", rd, 32'(m_ie));
    r = lfsr_take(32);
    reg_write(REG_THRESHOLD, r);
    m_thr = r[1:0];
    reg_read(REG_THRESHOLD, rd);
    check_eq("threshold", rd, 32'(m_thr));
    r = lfsr_take(32);
    reg_write(REG_MSIP, r);
    reg_read(REG_MSIP, rd);
    check_eq("msip", rd, 32'(r[0]));
    check_eq("msip_o", 32'(msip), 32'(r[0]));
    reg_write(8'h58, 32'hFFFF_FFFF);
    reg_read(8'h58, rd);
    check_eq("unmapped 58", rd, 32'h0);
    reg_read(8'hFC, rd);
    check_eq("unmapped fc", rd, 32'h0);
    report_test("register readback", err0);

    // Selection over random level sources and config
    err0 = errors;
    reg_write(REG_LE, 32'h0);
    m_le = '0;
    for (int k = 0; k < 4; k++) begin
      r = lfsr_take(16);
      @(negedge clk);
      // Reserved source 0 driven too but never pends
      intr_src = r[15:0];
      m_ip     = m_ip | {r[15:1], 1'b0};
      for (int s = 1; s < NSRC; s++) begin
        r = lfsr_take(2);
        m_prio[s] = r[1:0];
        reg_write(8'(4 * s), 32'(m_prio[s]));
      end
      r = lfsr_take(16);
      reg_write(REG_IE, r);
      m_ie = {r[15:1], 1'b0};
      r = lfsr_take(2);
      reg_write(REG_THRESHOLD, r);
      m_thr = r[1:0];
      settle();
      check_irq();
      check_ip();
    end
    report_test("priority selection", err0);

    // Claim and complete with every source enabled at nonzero priority
    err0 = errors;
    reg_write(REG_IE, 32'hFFFE);
    m_ie = 16'hFFFE;
    reg_write(REG_THRESHOLD, 32'h0);
    m_thr = '0;
    for (int s = 1; s < NSRC; s++) begin
      r = lfsr_take(2);
      m_prio[s] = (r[1:0] == 2'd0) ? 2'd3 : r[1:0];
      reg_write(8'(4 * s), 32'(m_prio[s]));
    end
    settle();
    check_irq();
    claim_all();
    // Claimed sources stay quiet while held high
    repeat (4) @(negedge clk);
    check_ip();
    complete_all();
    check_irq();
    @(negedge clk);
    intr_src = '0;
    claim_all();
    complete_all();
    report_test("level claim/complete", err0);

    // Edge sources with single-cycle pulses
    err0 = errors;
    reg_write(REG_LE, 32'hFFFE);
    m_le = 16'hFFFE;
    for (int k = 0; k < 3; k++) begin
      r = lfsr_take(4);
      e = 1 + (r % 15);
      pulse_src(e);
      m_ip[e] = 1'b1;
      settle();
      check_ip();
      check_irq();
      claim_all();
      // Lost while active
      pulse_src(e);
      settle();
      check_ip();
      complete_all();
    end
    report_test("edge sources", err0);

    end_run();
  end

endmodule

//--- tests/plic_props.sv
// PLIC properties: Wishbone ack handshake and target irq outputs, bound into the top level
`timescale 1ns/1ns

module plic_props #(
  parameter int SRCW = 4
) (
  input logic            clk_i,
  input logic            arst_n_i,
  input logic            cyc_i,
  input logic            stb_i,
  input logic            ack_i,
  input logic            irq_i,
  input logic [SRCW-1:0] irq_id_i
);

  // Failure count, read by the testbench at the end
  int fail_cnt = 0;

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  // Ack only in the cycle after a request
  ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |-> $past(cyc_i && stb_i))
    else begin
      $error("ack without a request in the previous cycle");
      fail_cnt++;
    end

  // Single-cycle ack
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |=> !ack_i)
    else begin
      $error("ack held high for two cycles");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Target outputs
  ////////////////////////////////////////

  // Id 0 means no interrupt
  irq_has_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_i |-> irq_id_i != '0)
    else begin
      $error("irq raised with id 0");
      fail_cnt++;
    end

  irq_low_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !irq_i)
    else begin
      $error("irq high while in reset");
      fail_cnt++;
    end

endmodule

bind plic_top plic_props #(
  .SRCW (SRCW)
) u_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .cyc_i    (wb_cyc_i),
  .stb_i    (wb_stb_i),
  .ack_i    (wb_ack_o),
  .irq_i    (irq_o),
  .irq_id_i (irq_id_o)
);

//--- verilog/plic_top.sv
// PLIC top level: register block, gateways and single target
`timescale 1ns/1ns

module plic_top #(
  parameter int  NUM_SRC  = 16,
  parameter int  MAX_PRIO = 3,
  localparam int PRIOW    = $clog2(MAX_PRIO + 1),
  localparam int SRCW     = $clog2(NUM_SRC)
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Wishbone classic slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [plic_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [plic_pkg::WB_DW-1:0]   wb_dat_i,
  input  logic [plic_pkg::WB_DW/8-1:0] wb_sel_i,
  output logic [plic_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                         wb_ack_o,
  // Interrupt sources, bit 0 reserved
  input  logic [NUM_SRC-1:0]           intr_src_i,
  // Target notification
  output logic                         irq_o,
  output logic [SRCW-1:0]              irq_id_o,
  output logic                         msip_o
);

  logic [NUM_SRC-1:0][PRIOW-1:0] prio;
  logic [NUM_SRC-1:0]            ie;
  logic [NUM_SRC-1:0]            le;
  logic [PRIOW-1:0]              threshold;
  logic [NUM_SRC-1:0]            claim;
  logic [NUM_SRC-1:0]            complete;
  logic [NUM_SRC-1:0]            ip;

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////
  plic_regs #(
    .NUM_SRC  (NUM_SRC),
    .MAX_PRIO (MAX_PRIO)
  ) u_regs (
    .clk_i, .arst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .ip_i (ip), .irq_id_i (irq_id_o),
    .prio_o (prio), .ie_o (ie), .le_o (le), .threshold_o (threshold),
    .msip_o, .claim_o (claim), .complete_o (complete)
  );

  // Gateways, one FSM per source
  plic_gateway #(
    .NUM_SRC (NUM_SRC)
  ) u_gateway (
    .clk_i, .arst_n_i,
    .src_i (intr_src_i), .le_i (le),
    .claim_i (claim), .complete_i (complete),
    .ip_o (ip)
  );

  // Single target
  plic_target #(
    .NUM_SRC  (NUM_SRC),
    .MAX_PRIO (MAX_PRIO)
  ) u_target (
    .clk_i, .arst_n_i,
    .ip_i (ip), .ie_i (ie), .prio_i (prio), .threshold_i (threshold),
    .irq_o, .irq_id_o
  );

endmodule

//--- plic/plic_target.sv
// PLIC target: highest-priority pending enabled source, registered irq and id
`timescale 1ns/1ns

module plic_target #(
  parameter int  NUM_SRC  = 16,
  parameter int  MAX_PRIO = 3,
  localparam int PRIOW    = $clog2(MAX_PRIO + 1),
  localparam int SRCW     = $clog2(NUM_SRC)
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [NUM_SRC-1:0]            ip_i,
  input  logic [NUM_SRC-1:0]            ie_i,
  input  logic [NUM_SRC-1:0][PRIOW-1:0] prio_i,
  input  logic [PRIOW-1:0]              threshold_i,
  output logic                          irq_o,
  output logic [SRCW-1:0]               irq_id_o
);

  logic [NUM_SRC-1:0] cand;
  logic [PRIOW-1:0]   best_prio;
  logic [SRCW-1:0]    best_id;

  // Candidates are pending and enabled
  assign cand = ip_i & ie_i;

  ////////////////////////////////////////
  // Selection
  ////////////////////////////////////////

  // Linear scan from id 0
  // Strict compare keeps the lowest id on a tie
  // Priority 0 never wins, it cannot beat any threshold
  always_comb begin
    best_prio = '0;
    best_id   = '0;
    for (int s = 0; s < NUM_SRC; s++) begin
      if (cand[s] && prio_i[s] > best_prio) begin
        best_prio = prio_i[s];
        best_id   = SRCW'(s);
      end
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // Winner must be strictly above threshold
  // Otherwise irq and id both go to 0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_o    <= 1'b0;
      irq_id_o <= '0;
    end else if (best_prio > threshold_i) begin
      irq_o    <= 1'b1;
      irq_id_o <= best_id;
    end else begin
      irq_o    <= 1'b0;
      irq_id_o <= '0;
    end
  end

endmodule

//--- plic/plic_gateway.sv
// PLIC gateway: per-source level/edge detection and pending/active tracking
`timescale 1ns/1ns

module plic_gateway #(
  parameter int NUM_SRC = 16
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [NUM_SRC-1:0] src_i,
  // 0 level, 1 edge
  input  logic [NUM_SRC-1:0] le_i,
  input  logic [NUM_SRC-1:0] claim_i,
  input  logic [NUM_SRC-1:0] complete_i,
  output logic [NUM_SRC-1:0] ip_o
);
  import plic_pkg::*;

  gw_state_e          state_q [NUM_SRC];
  logic [NUM_SRC-1:0] src_q;
  logic [NUM_SRC-1:0] evt_raw;
  logic [NUM_SRC-1:0] evt;

  // Previous sample for rising edge detect
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q <= '0;
    end else begin
      src_q <= src_i;
    end
  end

  // Level: high now, edge: low then high
  assign evt_raw = (~le_i & src_i) | (le_i & src_i & ~src_q);
  // Source 0 never raises an event
  assign evt     = {evt_raw[NUM_SRC-1:1], 1'b0};

  ////////////////////////////////////////
  // Per-source FSM
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        state_q[s] <= GW_IDLE;
      end
    end else begin
      for (int s = 0; s < NUM_SRC; s++) begin
        case (state_q[s])
          GW_IDLE:    if (evt[s])        state_q[s] <= GW_PENDING;
          GW_PENDING: if (claim_i[s])    state_q[s] <= GW_ACTIVE;
          // Events while active are dropped
          GW_ACTIVE:  if (complete_i[s]) state_q[s] <= GW_IDLE;
          default:                       state_q[s] <= GW_IDLE;
        endcase
      end
    end
  end

  // Pending straight from state
  always_comb begin
    for (int s = 0; s < NUM_SRC; s++) begin
      ip_o[s] = (state_q[s] == GW_PENDING);
    end
  end

endmodule

//--- plic/plic_regs.sv
// PLIC register block: Wishbone classic slave with config regs and claim/complete decode
`timescale 1ns/1ns

module plic_regs #(
  parameter int  NUM_SRC  = 16,
  parameter int  MAX_PRIO = 3,
  localparam int PRIOW    = $clog2(MAX_PRIO + 1),
  localparam int SRCW     = $clog2(NUM_SRC)
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Wishbone classic slave
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [plic_pkg::WB_AW-1:0]         wb_adr_i,
  input  logic [plic_pkg::WB_DW-1:0]         wb_dat_i,
  input  logic [plic_pkg::WB_DW/8-1:0]       wb_sel_i,
  output logic [plic_pkg::WB_DW-1:0]         wb_dat_o,
  output logic                               wb_ack_o,
  // Status from gateways and target
  input  logic [NUM_SRC-1:0]                 ip_i,
  input  logic [SRCW-1:0]                    irq_id_i,
  // Configuration out
  output logic [NUM_SRC-1:0][PRIOW-1:0]      prio_o,
  output logic [NUM_SRC-1:0]                 ie_o,
  output logic [NUM_SRC-1:0]                 le_o,
  output logic [PRIOW-1:0]                   threshold_o,
  output logic                               msip_o,
  // One-hot single-cycle pulses to the gateways
  output logic [NUM_SRC-1:0]                 claim_o,
  output logic [NUM_SRC-1:0]                 complete_o
);
  import plic_pkg::*;

  logic                             ack_q;
  logic                             acc;
  logic                             rd_en;
  logic                             wr_en;
  logic [WB_AW-1:0]                 adr_w;
  logic [WB_AW-1:0]                 prio_off;
  logic                             prio_hit;
  logic [SRCW-1:0]                  prio_idx;
  logic [WB_DW-1:0]                 wmask;
  logic [WB_DW-1:0]                 rdata;
  logic [WB_DW-1:0]                 wr_data;
  logic [WB_DW-1:0]                 dat_q;
  logic [NUM_SRC-1:0][PRIOW-1:0]    prio_q;
  logic [NUM_SRC-1:0]               ie_q;
  logic [NUM_SRC-1:0]               le_q;
  logic [PRIOW-1:0]                 thr_q;
  logic                             msip_q;

  ////////////////////////////////////////
  // Handshake and decode
  ////////////////////////////////////////

  // New request only while ack is low, so ack lasts one cycle
  assign acc   = wb_cyc_i & wb_stb_i & ~ack_q;
  assign rd_en = acc & ~wb_we_i;
  assign wr_en = acc & wb_we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
    end
  end

  // Word aligned address, byte offset ignored
  assign adr_w    = {wb_adr_i[WB_AW-1:2], 2'b00};
  // Priority window, one word per source
  assign prio_off = adr_w - REG_PRIO_BASE;
  assign prio_hit = (prio_off < WB_AW'(4 * NUM_SRC));
  assign prio_idx = prio_off[2 +: SRCW];

  // Byte lane mask from wb_sel_i
  always_comb begin
    for (int b = 0; b < WB_DW / 8; b++) begin
      wmask[8*b +: 8] = {8{wb_sel_i[b]}};
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  // Unmapped words fall through to zero
  always_comb begin
    rdata = '0;
    if (prio_hit) begin
      rdata[PRIOW-1:0] = prio_q[prio_idx];
    end else begin
      case (adr_w)
        REG_IP:        rdata[NUM_SRC-1:0] = ip_i;
        REG_LE:        rdata[NUM_SRC-1:0] = le_q;
        REG_IE:        rdata[NUM_SRC-1:0] = ie_q;
        REG_THRESHOLD: rdata[PRIOW-1:0]   = thr_q;
        REG_CC:        rdata[SRCW-1:0]    = irq_id_i;
        REG_MSIP:      rdata[0]           = msip_q;
        default:       ;
      endcase
    end
  end

  // Held for the ack cycle
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      dat_q <= rdata;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  // Unselected lanes keep the current value
  assign wr_data = (rdata & ~wmask) | (wb_dat_i & wmask);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q <= '0;
      ie_q   <= '0;
      le_q   <= '0;
      thr_q  <= '0;
      msip_q <= 1'b0;
    end else if (wr_en) begin
      if (prio_hit) begin
        prio_q[prio_idx] <= wr_data[PRIOW-1:0];
      end else begin
        case (adr_w)
          REG_LE:        le_q   <= wr_data[NUM_SRC-1:0];
          // Source 0 is reserved, enable stuck at 0
          REG_IE:        ie_q   <= {wr_data[NUM_SRC-1:1], 1'b0};
          REG_THRESHOLD: thr_q  <= wr_data[PRIOW-1:0];
          REG_MSIP:      msip_q <= wr_data[0];
          default:       ;
        endcase
      end
    end
  end

  assign prio_o      = prio_q;
  assign ie_o        = ie_q;
  assign le_o        = le_q;
  assign threshold_o = thr_q;
  assign msip_o      = msip_q;

  // Claim on CC read, gateway sees it at the ack edge
  always_comb begin
    claim_o = '0;
    if (rd_en && adr_w == REG_CC && irq_id_i != '0) begin
      claim_o[irq_id_i] = 1'b1;
    end
  end

  // Complete on CC write, ids out of range dropped
  always_comb begin
    complete_o = '0;
    if (wr_en && adr_w == REG_CC && wb_dat_i != '0 && wb_dat_i < WB_DW'(NUM_SRC)) begin
      complete_o[wb_dat_i[SRCW-1:0]] = 1'b1;
    end
  end

endmodule

//--- common/plic_pkg.sv
// PLIC shared definitions: Wishbone widths, register map and gateway states
package plic_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // Byte address width of the slave window
  localparam int WB_AW = 8;
  // Data width, four byte lanes
  localparam int WB_DW = 32;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Word offsets, priorities are one word per source from the base
  typedef enum logic [7:0] {
    REG_PRIO_BASE = 8'h00,
    REG_IP        = 8'h40,
    REG_LE        = 8'h44,
    REG_IE        = 8'h48,
    REG_THRESHOLD = 8'h4C,
    REG_CC        = 8'h50,
    REG_MSIP      = 8'h54
  } plic_reg_e;

  // Per-source gateway state
  typedef enum logic [1:0] {
    GW_IDLE    = 2'd0,
    GW_PENDING = 2'd1,
    GW_ACTIVE  = 2'd2
  } gw_state_e;

endpackage
